//--- av1_range_encoder.f
+incdir+.
av1_range_encoder_pkg.sv
stage_1_interval.sv
stage_2_range.sv
stage_3.sv
stage_4_carry.sv
av1_range_encoder.sv
tb_av1_range_encoder.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_av1_range_encoder
FILELIST  ?= av1_range_encoder.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf $(OBJ_DIR)

//--- tb_encoder_model.svh
`ifndef TB_ENCODER_MODEL_SVH
`define TB_ENCODER_MODEL_SVH

// ==============================
// Range coder reference model
// ==============================
int    m_range;                  // Coder range
int    m_low;                    // Coder low, 24 bits
int    m_s;                      // Bit count, zero stands for the AV1 start of -9
byte_t m_pend;                   // Byte waiting for a possible carry
bit    m_pvld;
int    m_run;                    // 0xFF bytes behind m_pend
byte_t exp_bytes[$];             // Resolved bytes in stream order
run_t  exp_runs[$];              // Run length of each expected chunk

function automatic void model_reset();
    m_range = 32'h8000;
    m_low   = 0;
    m_s     = 0;
    m_pend  = '0;
    m_pvld  = 1'b0;
    m_run   = 0;
endfunction

// Carry rule for one 9-bit value
function automatic void resolve_byte(input logic [8:0] c, inout bit emitted);
    if (!m_pvld) begin
        m_pend = c[7:0];         // First byte only fills the slot
        m_pvld = 1'b1;
    end else if (c[7:0] == 8'hFF && !c[8]) begin
        m_run++;
    end else begin
        if (!emitted) exp_runs.push_back(run_t'(m_run));   // One chunk per request
        exp_bytes.push_back(byte_t'(int'(m_pend) + int'(c[8])));
        repeat (m_run) exp_bytes.push_back(c[8] ? 8'h00 : 8'hFF);
        m_pend  = c[7:0];
        m_run   = 0;
        emitted = 1'b1;
    end
endfunction

function automatic void model_encode(input sym_req_t r);
    int         u, v, nr, lo, d, s_c;
    logic [8:0] c;
    bit         emitted;
    emitted = 1'b0;
    lo      = m_low;
    if (r.bool_mode) begin
        v = (((m_range >> 8) * (int'(r.fl) >> 6)) >> 1) + EC_MIN_PROB;
        if (r.lsb_symbol) begin
            lo = m_low + m_range - v;   // Skip the lower part
            nr = v;
        end else begin
            nr = m_range - v;
        end
    end else begin
        u = (((m_range >> 8) * (int'(r.fl) >> 6)) >> 1)
            + EC_MIN_PROB * (int'(r.nsyms) - int'(r.sym));
        v = (((m_range >> 8) * (int'(r.fh) >> 6)) >> 1)
            + EC_MIN_PROB * (int'(r.nsyms) - int'(r.sym) - 1);
        if (int'(r.fl) < CDF_TOP) begin
            lo = m_low + m_range - u;
            nr = u - v;
        end else begin
            nr = m_range - v;            // Symbol zero keeps low
        end
    end
    lo = lo & 32'hFF_FFFF;
    nr = nr & 32'hFFFF;
    d  = 0;
    while (d < 15 && ((nr >> (15 - d)) & 1) == 0) d++;   // Leading zeros
    m_range = (nr << d) & 32'hFFFF;
    s_c     = m_s + d;
    if (s_c >= 9) begin
        c  = 9'((lo >> (m_s + 7)) & 32'h1FF);
        resolve_byte(c, emitted);
        lo = lo & ((1 << (m_s + 7)) - 1);
        if (s_c >= 17) begin
            c   = 9'((lo >> (m_s - 1)) & 32'h1FF);   // Second byte just below
            resolve_byte(c, emitted);
            lo  = lo & ((1 << (m_s - 1)) - 1);
            s_c = s_c - 16;
        end else begin
            s_c = s_c - 8;
        end
    end
    m_low = (lo << d) & 32'hFF_FFFF;
    m_s   = s_c;
endfunction

`endif

//--- tb_av1_range_encoder.sv
`timescale 1ns/100ps

module tb_av1_range_encoder
    import av1_range_encoder_pkg::*;
();

    localparam int N_BOOL      = 2000;
    localparam int N_MULTI     = 2000;
    localparam int N_CARRY     = 2000;
    localparam int N_GAP       = 500;    // Sent twice
    localparam int N_RST       = 400;
    localparam int TOTAL_REQ   = N_BOOL + N_MULTI + N_CARRY + 2 * N_GAP + N_RST;
    localparam int CYCLE_LIMIT = 2 * TOTAL_REQ + 200;

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    logic     sym_valid = 1'b0;
    sym_req_t sym_req = '0;
    logic     chunk_valid;
    chunk_t   chunk;

    int       errors, checks, tests, cycles;
    int       n_run_chunks, n_tail_chunks;
    byte_t    got_bytes[$];              // DUT stream since last reset
    byte_t    ref_bytes[$];
    sym_req_t reqs[$];

    `include "tb_encoder_model.svh"

    always #10 clk = ~clk;               // 20 ns period

    av1_range_encoder u_dut (
        .clk         (clk),
        .rst         (rst),
        .sym_valid   (sym_valid),
        .sym_req     (sym_req),
        .chunk_valid (chunk_valid),
        .chunk       (chunk)
    );

    // ==============================
    // Compare tasks
    // ==============================
    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got 0x%02h, expected 0x%02h",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_run(input run_t got, input run_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: run_len got %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic expect_byte(input byte_t got);
        got_bytes.push_back(got);
        if (exp_bytes.size() == 0) begin
            errors++;
            $display("DUT emitted byte 0x%02h at %0t that the model did not produce", got, $time);
        end else begin
            check_byte(got, exp_bytes.pop_front(), "stream byte");
        end
    endtask

    // Chunk monitor, sampled after the edge settles
    always @(posedge clk) begin
        #1;
        if (rst && chunk_valid) begin
            errors++;
            $display("chunk_valid was high during reset at %0t", $time);
        end else if (chunk_valid) begin
            if (exp_runs.size() == 0) begin
                errors++;
                $display("DUT emitted a chunk at %0t that the model did not expect", $time);
            end else begin
                check_run(chunk.run_len, exp_runs.pop_front());
            end
            if (chunk.run_len != 0) n_run_chunks++;
            if (chunk.has_tail) n_tail_chunks++;
            expect_byte(chunk.head);
            for (int i = 0; i < int'(chunk.run_len); i++) expect_byte(chunk.run_byte);
            if (chunk.has_tail) expect_byte(chunk.tail);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    task automatic send(input sym_req_t r);
        @(negedge clk);
        sym_valid = 1'b1;
        sym_req   = r;
        model_encode(r);                 // Model follows every strobe
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            sym_valid = 1'b0;
            sym_req   = '0;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst       = 1'b1;
        sym_valid = 1'b0;
        exp_bytes.delete();              // In-flight bytes die with the reset
        exp_runs.delete();
        repeat (16) @(negedge clk);
        rst = 1'b0;
        model_reset();
        got_bytes.delete();
    endtask

    function automatic sym_req_t rand_bool(input int fl_max, input int one_in);
        sym_req_t r;
        r            = '0;
        r.bool_mode  = 1'b1;
        r.fl         = prob_t'(1 + $urandom % fl_max);   // Q15 below 1.0
        r.lsb_symbol = ($urandom % one_in) != 0;
        return r;
    endfunction

    function automatic sym_req_t rand_multi();
        sym_req_t r;
        int       n, s, fl, fh;
        r       = '0;
        n       = 2 + $urandom % 15;
        s       = $urandom % n;
        fl      = (s == 0) ? CDF_TOP : 1 + $urandom % (CDF_TOP - 1);
        fh      = (s == n - 1) ? 0 : $urandom % fl;      // Keeps fl above fh
        r.fl    = prob_t'(fl);
        r.fh    = prob_t'(fh);
        r.sym   = sym_t'(s);
        r.nsyms = sym_t'(n);
        return r;
    endfunction

    task automatic finish_test(input string name, input int err_before);
        idle(4);                         // Two-cycle latency drains
        if (exp_bytes.size() != 0) begin
            errors++;
            $display("%s: %0d expected bytes never came out of the DUT", name, exp_bytes.size());
        end
        tests++;
        $display("Test %s done, %0d errors", name, errors - err_before);
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        int e0;
        void'($urandom(86));
        apply_reset();

        e0 = errors;
        for (int i = 0; i < N_BOOL; i++) send(rand_bool(CDF_TOP - 1, 2));
        finish_test("bool", e0);

        apply_reset();
        e0 = errors;
        for (int i = 0; i < N_MULTI; i++) send(rand_multi());
        finish_test("multi", e0);

        apply_reset();                   // Unlikely branches pile up 0xFF bytes
        e0            = errors;
        n_run_chunks  = 0;
        n_tail_chunks = 0;
        for (int i = 0; i < N_CARRY; i++) begin
            if ($urandom % 4 != 0) send(rand_bool(1024, 4));
            else send(rand_multi());
        end
        idle(4);
        if (n_run_chunks == 0 || n_tail_chunks == 0) begin
            errors++;
            $display("Carry stream missed a case, %0d chunks with runs, %0d with tail",
                     n_run_chunks, n_tail_chunks);
        end
        finish_test("carry", e0);

        reqs.delete();
        for (int i = 0; i < N_GAP; i++) reqs.push_back((i % 2 == 0) ? rand_bool(CDF_TOP - 1, 2)
                                                                     : rand_multi());
        apply_reset();
        e0 = errors;
        foreach (reqs[i]) send(reqs[i]);
        idle(4);
        ref_bytes = got_bytes;           // Back to back result
        apply_reset();
        foreach (reqs[i]) begin
            idle(int'($urandom % 3));
            send(reqs[i]);
        end
        idle(4);
        if (got_bytes.size() != ref_bytes.size()) begin
            errors++;
            $display("Gapped stream gave %0d bytes, back to back gave %0d",
                     got_bytes.size(), ref_bytes.size());
        end else begin
            foreach (ref_bytes[i]) check_byte(got_bytes[i], ref_bytes[i], "gapped byte");
        end
        finish_test("gaps", e0);

        apply_reset();
        e0 = errors;
        for (int i = 0; i < N_RST / 2; i++) send(rand_multi());
        apply_reset();                   // Requests still in flight
        for (int i = 0; i < N_RST / 2; i++) send(rand_bool(CDF_TOP - 1, 2));
        finish_test("reset", e0);

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- av1_range_encoder.sv
`timescale 1ns/100ps

module av1_range_encoder
    import av1_range_encoder_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     sym_valid,     // One request per strobe
    input  sym_req_t sym_req,
    output logic     chunk_valid,
    output chunk_t   chunk
);

    range_t      range;             // Current range register
    range_ext_t  u, v_bool;
    logic        comp_mux_1;
    stage2_out_t s2;
    logic        s2_valid;
    stage3_out_t res;
    low_t        low;               // Fed back from stage 4
    shift_t      s;

    // ==============================
    // Pipeline
    // ==============================
    stage_1_interval u_stage_1 (
        .req        (sym_req),
        .range      (range),
        .u          (u),
        .v_bool     (v_bool),
        .comp_mux_1 (comp_mux_1)
    );

    stage_2_range u_stage_2 (
        .clk        (clk),
        .rst        (rst),
        .sym_valid  (sym_valid),
        .req        (sym_req),
        .u          (u),
        .v_bool     (v_bool),
        .comp_mux_1 (comp_mux_1),
        .range      (range),
        .s2         (s2),
        .s2_valid   (s2_valid)
    );

    stage_3 u_stage_3 (
        .s2     (s2),
        .in_low (low),
        .in_s   (s),
        .res    (res)
    );

    stage_4_carry u_stage_4 (
        .clk         (clk),
        .rst         (rst),
        .s2_valid    (s2_valid),
        .res         (res),
        .low         (low),
        .s           (s),
        .chunk_valid (chunk_valid),
        .chunk       (chunk)
    );

endmodule

//--- stage_4_carry.sv
`timescale 1ns/100ps

module stage_4_carry
    import av1_range_encoder_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        s2_valid,
    input  stage3_out_t res,
    output low_t        low,
    output shift_t      s,
    output logic        chunk_valid,
    output chunk_t      chunk
);

    byte_t  pend_q;                  // Byte held back for a late carry
    logic   pend_vld_q;
    run_t   run_q;                   // 0xFF bytes queued behind pend_q

    logic   do_1, do_2;
    logic   emit_1, emit_2;
    byte_t  head_1, head_2;
    byte_t  rb_1, rb_2;              // Run byte after carry
    byte_t  pend_1, pend_2;
    logic   pvld_1, pvld_2;
    run_t   run_1, run_2;
    chunk_t chunk_d;

    // One 9-bit value through the carry rule
    function automatic void carry_step(
        input  byte_t      pend,
        input  logic       pend_vld,
        input  run_t       run,
        input  logic [8:0] c,
        output logic       emit,
        output byte_t      head,
        output byte_t      run_byte,
        output byte_t      pend_n,
        output logic       pend_vld_n,
        output run_t       run_n
    );
        emit       = 1'b0;
        head       = pend + byte_t'(c[8]);
        run_byte   = c[8] ? 8'h00 : 8'hFF;   // 0xFF plus carry wraps
        pend_n     = pend;
        pend_vld_n = pend_vld;
        run_n      = run;
        if (!pend_vld) begin                 // First byte, nothing below to carry into
            pend_n     = c[7:0];
            pend_vld_n = 1'b1;
        end else if ((c[7:0] == 8'hFF) && !c[8]) begin
            run_n = run + run_t'(1);         // Still unresolved
        end else begin
            emit   = 1'b1;
            pend_n = c[7:0];
            run_n  = '0;
        end
    endfunction

    // ==============================
    // Carry resolution
    // ==============================
    always_comb begin
        do_1 = s2_valid && (res.flag_bitstream != 2'd0);
        do_2 = s2_valid && (res.flag_bitstream == 2'd2);

        carry_step(pend_q, pend_vld_q, run_q, res.bit_1[8:0],
                   emit_1, head_1, rb_1, pend_1, pvld_1, run_1);
        if (!do_1) begin
            emit_1 = 1'b0;
            pend_1 = pend_q;
            pvld_1 = pend_vld_q;
            run_1  = run_q;
        end

        carry_step(pend_1, pvld_1, run_1, res.bit_2[8:0],
                   emit_2, head_2, rb_2, pend_2, pvld_2, run_2);
        if (!do_2) begin
            emit_2 = 1'b0;
            pend_2 = pend_1;
            pvld_2 = pvld_1;
            run_2  = run_1;
        end

        // Double emission, second is one byte since run_1 is zero
        chunk_d          = '0;
        chunk_d.has_tail = emit_1 && emit_2;
        chunk_d.tail     = head_2;
        if (emit_1) begin
            chunk_d.head     = head_1;
            chunk_d.run_len  = run_q;
            chunk_d.run_byte = rb_1;
        end else begin
            chunk_d.head     = head_2;
            chunk_d.run_len  = run_1;
            chunk_d.run_byte = rb_2;
        end
    end

    // ==============================
    // Registers
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            low         <= '0;
            s           <= S_INIT;
            pend_vld_q  <= 1'b0;
            run_q       <= '0;
            chunk_valid <= 1'b0;
        end else begin
            chunk_valid <= emit_1 || emit_2;
            if (s2_valid) begin
                low        <= res.low;   // Feedback into stage 3
                s          <= res.s;
                pend_vld_q <= pvld_2;
                run_q      <= run_2;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            pend_q <= pend_2;
        end
        if (emit_1 || emit_2) begin
            chunk <= chunk_d;
        end
    end

endmodule

//--- stage_3.sv
`timescale 1ns/100ps

module stage_3
    import av1_range_encoder_pkg::*;
(
    input  stage2_out_t s2,
    input  low_t        in_low,
    input  shift_t      in_s,
    output stage3_out_t res
);

    low_t   iso_bool_m, iso_mux_m;         // Isolation enables per path
    low_t   iso_bool_low, iso_mux_low;
    range_t iso_bool_range, iso_bool_v;
    range_t iso_mux_range, iso_mux_u;
    low_t   low_bool, low_mux, low;

    shift_t s_comp;                        // Count after shifting by d
    shift_t c_s0, c_s8;                    // Byte positions in low
    shift_t c_int_s0, c_int_s8;
    shift_t s_s0, s_s8;
    low_t   m_s0, m_s8;
    low_t   low_s0, low_s8;
    logic   emit_1, emit_2;

    // ==============================
    // Low update
    // ==============================
    // Idle path sees zero operands
    assign iso_bool_m = {LOW_WIDTH{s2.bool_mode & s2.lsb_symbol}};
    assign iso_mux_m  = {LOW_WIDTH{~s2.bool_mode & s2.comp_mux_1}};

    assign iso_bool_low   = in_low & iso_bool_m;
    assign iso_bool_range = s2.in_range & iso_bool_m[RANGE_WIDTH-1:0];
    assign iso_bool_v     = s2.v_bool[RANGE_WIDTH-1:0] & iso_bool_m[RANGE_WIDTH-1:0];

    assign iso_mux_low    = in_low & iso_mux_m;
    assign iso_mux_range  = s2.in_range & iso_mux_m[RANGE_WIDTH-1:0];
    assign iso_mux_u      = s2.u[RANGE_WIDTH-1:0] & iso_mux_m[RANGE_WIDTH-1:0];

    // Upper part of the split is skipped over
    assign low_bool = s2.lsb_symbol ?
                      iso_bool_low + (low_t'(iso_bool_range) - low_t'(iso_bool_v)) : in_low;
    assign low_mux  = s2.comp_mux_1 ?
                      iso_mux_low + (low_t'(iso_mux_range) - low_t'(iso_mux_u)) : in_low;
    assign low      = s2.bool_mode ? low_bool : low_mux;

    // ==============================
    // Normalization
    // ==============================
    assign s_comp = in_s + s2.d;
    assign emit_1 = (s_comp >= 5'd9);      // At least one byte complete
    assign emit_2 = (s_comp >= 5'd17);     // Two bytes complete

    assign c_s0     = in_s + 5'd7;
    assign c_s8     = in_s - 5'd1;
    assign c_int_s0 = in_s + 5'd16;        // Wraps, fixed up by the -24 below
    assign c_int_s8 = in_s + 5'd8;

    assign m_s0   = (low_t'(1) << c_s0) - low_t'(1);   // Bits under first byte
    assign m_s8   = m_s0 >> 8;                         // Bits under second byte
    assign low_s0 = low & m_s0;
    assign low_s8 = low_s0 & m_s8;

    assign s_s0 = c_int_s0 + s2.d - 5'd24;
    assign s_s8 = c_int_s8 + s2.d - 5'd24;

    // ==============================
    // Outputs and pre-bitstream
    // ==============================
    always_comb begin
        if (emit_2) begin
            res.low            = low_s8 << s2.d;
            res.s              = s_s8;
            res.flag_bitstream = 2'd2;
        end else if (emit_1) begin
            res.low            = low_s0 << s2.d;
            res.s              = s_s0;
            res.flag_bitstream = 2'd1;
        end else begin
            res.low            = low << s2.d;
            res.s              = s_comp;
            res.flag_bitstream = 2'd0;
        end
        res.bit_1 = emit_1 ? range_t'(low >> c_s0) : '0;      // Carry lands in bit 8
        res.bit_2 = emit_2 ? range_t'(low_s0 >> c_s8) : '0;   // Follows bit_1 in stream
    end

endmodule

//--- stage_2_range.sv
`timescale 1ns/100ps

module stage_2_range
    import av1_range_encoder_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        sym_valid,
    input  sym_req_t    req,
    input  range_ext_t  u,
    input  range_ext_t  v_bool,
    input  logic        comp_mux_1,
    output range_t      range,
    output stage2_out_t s2,
    output logic        s2_valid
);

    range_ext_t rng_new_ext;
    range_t     rng_new;       // Unnormalized new range
    range_t     range_ready;
    shift_t     d;

    // ==============================
    // New range
    // ==============================
    always_comb begin
        if (req.bool_mode) begin
            rng_new_ext = req.lsb_symbol ? v_bool : range_ext_t'(range) - v_bool;
        end else begin
            rng_new_ext = comp_mux_1 ? u - v_bool : range_ext_t'(range) - v_bool;
        end
    end

    assign rng_new = rng_new_ext[RANGE_WIDTH-1:0];

    // Leading zero count, highest set bit wins
    always_comb begin
        d = shift_t'(RANGE_WIDTH);   // Zero range, not reachable with a valid CDF
        for (int i = 0; i < RANGE_WIDTH; i++) begin
            if (rng_new[i]) begin
                d = shift_t'(RANGE_WIDTH - 1 - i);
            end
        end
    end

    assign range_ready = rng_new << d;   // MSB back at bit 15

    // ==============================
    // Registers
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            range    <= RANGE_INIT;
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= sym_valid;
            if (sym_valid) begin
                range <= range_ready;
            end
        end
    end

    // Stage 3 payload, low trails range by one stage
    always_ff @(posedge clk) begin
        if (sym_valid) begin
            s2.in_range    <= range;
            s2.range_ready <= range_ready;
            s2.d           <= d;
            s2.u           <= u;
            s2.v_bool      <= v_bool;
            s2.comp_mux_1  <= comp_mux_1;
            s2.bool_mode   <= req.bool_mode;
            s2.lsb_symbol  <= req.lsb_symbol;
        end
    end

endmodule

//--- stage_1_interval.sv
`timescale 1ns/100ps

module stage_1_interval
    import av1_range_encoder_pkg::*;
(
    input  sym_req_t   req,
    input  range_t     range,
    output range_ext_t u,
    output range_ext_t v_bool,
    output logic       comp_mux_1
);

    logic [17:0] prod_fl, prod_fh;   // 8 x 10 bit products
    range_ext_t  scale_fl, scale_fh;
    sym_t        n_u, n_v;           // Symbols left above each bound
    range_ext_t  u_ms, v_ms, v_bl;

    // ==============================
    // Scaled CDF bounds
    // ==============================
    assign prod_fl = range[RANGE_WIDTH-1:8] * req.fl[PROB_WIDTH-1:EC_PROB_SHIFT];
    assign prod_fh = range[RANGE_WIDTH-1:8] * req.fh[PROB_WIDTH-1:EC_PROB_SHIFT];

    assign scale_fl = range_ext_t'(prod_fl >> 1);
    assign scale_fh = range_ext_t'(prod_fh >> 1);

    assign n_u = req.nsyms - req.sym;
    assign n_v = n_u - sym_t'(1);

    // Minimum probability steps keep every symbol codable
    assign u_ms = scale_fl + range_ext_t'(EC_MIN_PROB * n_u);
    assign v_ms = scale_fh + range_ext_t'(EC_MIN_PROB * n_v);
    assign v_bl = scale_fl + range_ext_t'(EC_MIN_PROB);   // Bool split point

    // ==============================
    // Outputs
    // ==============================
    assign u          = req.bool_mode ? range_ext_t'(range) : u_ms;   // Bool upper bound is whole range
    assign v_bool     = req.bool_mode ? v_bl : v_ms;
    assign comp_mux_1 = (req.fl < prob_t'(CDF_TOP));   // Upper bound below 1.0

endmodule

//--- av1_range_encoder_pkg.sv
package av1_range_encoder_pkg;

    // ==============================
    // Widths and coder constants
    // ==============================
    localparam int RANGE_WIDTH   = 16;
    localparam int LOW_WIDTH     = 24;
    localparam int D_SIZE        = 5;
    localparam int PROB_WIDTH    = 16;      // Q15 CDF values
    localparam int NSYMS_WIDTH   = 5;
    localparam int EC_MIN_PROB   = 4;       // Minimum probability step per symbol
    localparam int EC_PROB_SHIFT = 6;       // CDF bits dropped before the multiply
    localparam int CDF_TOP       = 32768;   // 1.0 in Q15

    // ==============================
    // Vector types
    // ==============================
    typedef logic [RANGE_WIDTH-1:0] range_t;
    typedef logic [RANGE_WIDTH:0]   range_ext_t;   // One headroom bit
    typedef logic [LOW_WIDTH-1:0]   low_t;
    typedef logic [D_SIZE-1:0]      shift_t;       // Shift d and bit count s
    typedef logic [PROB_WIDTH-1:0]  prob_t;
    typedef logic [NSYMS_WIDTH-1:0] sym_t;
    typedef logic [7:0]             byte_t;
    typedef logic [7:0]             run_t;         // Pending 0xFF count

    localparam range_t RANGE_INIT = 16'h8000;
    // Bit count is held offset by 9, so 0 here is the AV1 start count of -9
    localparam shift_t S_INIT     = '0;

    // ==============================
    // Structs
    // ==============================
    typedef struct packed {
        prob_t fl;
        prob_t fh;
        sym_t  sym;
        sym_t  nsyms;
        logic  bool_mode;
        logic  lsb_symbol;                  // Bool value in bool mode
    } sym_req_t;

    typedef struct packed {
        range_t     in_range;               // Range before this symbol
        range_t     range_ready;            // Normalized new range
        shift_t     d;
        range_ext_t u;
        range_ext_t v_bool;
        logic       comp_mux_1;
        logic       bool_mode;
        logic       lsb_symbol;
    } stage2_out_t;

    typedef struct packed {
        low_t       low;
        shift_t     s;
        range_t     bit_1;                  // Byte plus carry in [8:0]
        range_t     bit_2;
        logic [1:0] flag_bitstream;         // 0 none, 1 bit_1, 2 both
    } stage3_out_t;

    typedef struct packed {
        byte_t head;
        run_t  run_len;
        byte_t run_byte;
        logic  has_tail;
        byte_t tail;
    } chunk_t;

endpackage
